// ==== verilog/dcache_mem_pkg.sv ====
//##########################################################################
// access sizes, bus commands, field widths and queue payload structs
//##########################################################################

package dcache_mem_pkg;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_cmd_t;

    localparam int ADDR_W    = 16;
    localparam int IDX_W     = 5;
    localparam int CTAG_W    = 8;
    localparam int MEM_TAG_W = 4;
    // widest lsq grant a queue entry can carry
    localparam int GNT_W     = 16;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [63:0]       data;
        mem_size_t         size;
        logic              is_store;
        logic [GNT_W-1:0]  gnt;
    } mem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        mem_size_t            size;
        logic [MEM_TAG_W-1:0] tag;
        logic [GNT_W-1:0]     gnt;
    } pend_t;

endpackage

// ==== verilog/miss_request_packer.sv ====
//##########################################################################
// request capture and lane packing for the issue queue
//##########################################################################

`timescale 1ns/1ps

module miss_request_packer
    import dcache_mem_pkg::*;
#(
    parameter int LSQ_SIZE = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  except,
    input  logic                  wb_en,
    input  logic [ADDR_W-1:0]     wb_addr,
    input  logic [63:0]           wb_data,
    input  logic                  wr_en,
    input  logic [ADDR_W-1:0]     wr_addr,
    input  logic [63:0]           wr_data,
    input  mem_size_t             wr_size,
    input  logic                  rd_en,
    input  logic [ADDR_W-1:0]     rd_addr,
    input  mem_size_t             rd_size,
    input  logic [LSQ_SIZE-1:0]   rd_gnt,
    output logic [2:0]            push_valid,
    output mem_req_t [2:0]        push_data,
    output logic [2:0]            push_cancelable
);

    // slot 0 writeback, slot 1 store, slot 2 load
    logic [2:0]     req_valid;
    mem_req_t [2:0] req_q;
    logic [2:0]     lane_req;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_valid <= '0;
        end else begin
            req_valid <= {rd_en & ~except, wr_en, wb_en};
        end
    end

    always_ff @(posedge clock) begin
        req_q[0] <= '{addr: wb_addr, data: wb_data, size: DOUBLE, is_store: 1'b1, gnt: '0};
        req_q[1] <= '{addr: wr_addr, data: wr_data, size: wr_size, is_store: 1'b1, gnt: '0};
        req_q[2] <= '{addr: rd_addr, data: '0, size: rd_size, is_store: 1'b0,
                      gnt: GNT_W'(rd_gnt)};
    end

    // held load dies if except rises now
    assign lane_req = {req_valid[2] & ~except, req_valid[1:0]};

    // compact into the lowest lanes, keeping priority order
    always_comb begin
        logic [1:0] lane;
        lane            = 2'd0;
        push_valid      = '0;
        push_data       = '0;
        push_cancelable = '0;
        for (int i = 0; i < 3; i++) begin
            if (lane_req[i]) begin
                push_valid[lane]      = 1'b1;
                push_data[lane]       = req_q[i];
                push_cancelable[lane] = (i == 2);
                lane                  = lane + 2'd1;
            end
        end
    end

endmodule

// ==== verilog/tag_fifo.sv ====
//##########################################################################
// circular queue, one-hot pointers, multi-lane push, cancel by kill
//##########################################################################

`timescale 1ns/1ps

module tag_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  DEPTH      = 16,
    parameter int  PUSH_LANES = 1
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         kill,
    input  logic [PUSH_LANES-1:0]        push_valid,
    input  payload_t [PUSH_LANES-1:0]    push_data,
    input  logic [PUSH_LANES-1:0]        push_cancelable,
    input  logic                         pop,
    output payload_t                     head_data,
    output logic                         head_live,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   free_count
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         store [DEPTH];
    logic [DEPTH-1:0] live;
    logic [DEPTH-1:0] cancelable;
    logic [DEPTH-1:0] head_ptr;
    logic [DEPTH-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_count;
    logic [DEPTH-1:0] lane_ptr [PUSH_LANES+1];

    function automatic logic [DEPTH-1:0] rotate(input logic [DEPTH-1:0] ptr);
        return {ptr[DEPTH-2:0], ptr[DEPTH-1]};
    endfunction

    // slot taken by each lane, in lane order
    always_comb begin
        lane_ptr[0] = tail_ptr;
        push_count  = '0;
        for (int i = 0; i < PUSH_LANES; i++) begin
            lane_ptr[i+1] = push_valid[i] ? rotate(lane_ptr[i]) : lane_ptr[i];
            push_count    = push_count + CNT_W'(push_valid[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= {{(DEPTH-1){1'b0}}, 1'b1};
            tail_ptr <= {{(DEPTH-1){1'b0}}, 1'b1};
            count    <= '0;
        end else begin
            head_ptr <= pop ? rotate(head_ptr) : head_ptr;
            tail_ptr <= lane_ptr[PUSH_LANES];
            count    <= count + push_count - CNT_W'(pop);
        end
    end

    // entries pushed during kill arrive already dead
    always_ff @(posedge clock) begin
        if (reset) begin
            live       <= '0;
            cancelable <= '0;
        end else begin
            for (int j = 0; j < DEPTH; j++) begin
                if (kill && cancelable[j])
                    live[j] <= 1'b0;
                for (int i = 0; i < PUSH_LANES; i++) begin
                    if (push_valid[i] && lane_ptr[i][j]) begin
                        live[j]       <= ~(push_cancelable[i] & kill);
                        cancelable[j] <= push_cancelable[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < DEPTH; j++) begin
            for (int i = 0; i < PUSH_LANES; i++) begin
                if (push_valid[i] && lane_ptr[i][j])
                    store[j] <= push_data[i];
            end
        end
    end

    always_comb begin
        head_data = '0;
        head_live = 1'b0;
        for (int j = 0; j < DEPTH; j++) begin
            if (head_ptr[j]) begin
                head_data = store[j];
                head_live = live[j];
            end
        end
    end

    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(DEPTH));
    assign free_count = CNT_W'(DEPTH) - count;

    // no input back-pressure, so the producers must never overrun
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push_count <= free_count)
        else $error("tag_fifo push of %0d with %0d free", push_count, free_count);

    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        pop |-> !empty)
        else $error("tag_fifo pop while empty");

endmodule

// ==== verilog/issue_fsm.sv ====
//##########################################################################
// bus command issue, refusal backoff and pending-load recording
//##########################################################################

`timescale 1ns/1ps

module issue_fsm
    import dcache_mem_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  mem_req_t              head_data,
    input  logic                  head_live,
    input  logic                  issue_empty,
    input  logic                  pend_full,
    input  logic [MEM_TAG_W-1:0]  mem2proc_response,
    input  logic                  timer_busy,
    output logic                  issue_pop,
    output logic                  pend_push,
    output pend_t                 pend_data,
    output logic                  timer_start,
    output bus_cmd_t              Dmem_command,
    output logic [ADDR_W-1:0]     Dmem_addr,
    output mem_size_t             Dmem_size,
    output logic [63:0]           Dmem_data
);

    typedef enum logic [1:0] {IDLE, ISSUE, BACKOFF, HOLD} state_t;

    state_t state;
    state_t state_next;
    logic   head_load;
    logic   waiting;
    logic   skip;
    logic   blocked;
    logic   drive;
    logic   accepted;

    assign head_load = !head_data.is_store;
    assign waiting   = (state == BACKOFF) && timer_busy;
    // cancelled load leaves without touching the bus
    assign skip      = !issue_empty && head_load && !head_live;
    assign blocked   = !issue_empty && head_load && head_live && pend_full;
    assign drive     = !issue_empty && !waiting && !skip && !blocked;
    assign accepted  = drive && (mem2proc_response != '0);

    assign issue_pop   = accepted || skip;
    assign pend_push   = accepted && head_load;
    assign timer_start = drive && (mem2proc_response == '0);

    always_comb begin
        pend_data.addr = head_data.addr;
        pend_data.size = head_data.size;
        pend_data.tag  = mem2proc_response;
        pend_data.gnt  = head_data.gnt;
    end

    // loads always fetch the whole doubleword
    always_comb begin
        Dmem_command = BUS_NONE;
        Dmem_addr    = '0;
        Dmem_size    = BYTE;
        Dmem_data    = '0;
        if (drive) begin
            Dmem_addr = head_data.addr;
            if (head_load) begin
                Dmem_command = BUS_LOAD;
                Dmem_size    = DOUBLE;
            end else begin
                Dmem_command = BUS_STORE;
                Dmem_size    = head_data.size;
                Dmem_data    = head_data.data;
            end
        end
    end

    always_comb begin
        if (timer_start || waiting) begin
            state_next = BACKOFF;
        end else if (blocked) begin
            state_next = HOLD;
        end else if (issue_empty) begin
            state_next = IDLE;
        end else begin
            state_next = ISSUE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== verilog/retry_timer.sv ====
//##########################################################################
// backoff down-counter after a refused bus command
//##########################################################################

`timescale 1ns/1ps

module retry_timer #(
    parameter int RETRY_WAIT = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic busy
);

    localparam int CNT_W = (RETRY_WAIT < 1) ? 1 : $clog2(RETRY_WAIT + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(RETRY_WAIT);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // the issuer must stay quiet for the whole backoff
    a_no_restart: assert property (@(posedge clock) disable iff (reset)
        start |-> !busy)
        else $error("retry_timer restarted while busy");

endmodule

// ==== verilog/load_aligner.sv ====
//##########################################################################
// return tag match, cache fill and sized load data for the lsq
//##########################################################################

`timescale 1ns/1ps

module load_aligner
    import dcache_mem_pkg::*;
#(
    parameter int LSQ_SIZE = 16
) (
    input  pend_t                 pend_head,
    input  logic                  pend_live,
    input  logic                  pend_empty,
    input  logic [MEM_TAG_W-1:0]  mem2proc_tag,
    input  logic [63:0]           mem2proc_data,
    output logic                  pend_pop,
    output logic                  mem_wr_en,
    output logic [IDX_W-1:0]      mem_wr_idx,
    output logic [CTAG_W-1:0]     mem_wr_tag,
    output logic [63:0]           mem_wr_data,
    output logic [LSQ_SIZE-1:0]   mem_feedback,
    output logic [31:0]           mem_data
);

    logic        live_hit;
    logic [63:0] size_mask;
    logic [63:0] shifted;

    // tag 0 is an empty return slot
    assign pend_pop = !pend_empty && (mem2proc_tag != '0) && (mem2proc_tag == pend_head.tag);
    assign live_hit = pend_pop && pend_live;

    always_comb begin
        case (pend_head.size)
            BYTE:    size_mask = 64'h0000_0000_0000_00ff;
            HALF:    size_mask = 64'h0000_0000_0000_ffff;
            WORD:    size_mask = 64'h0000_0000_ffff_ffff;
            default: size_mask = '1;
        endcase
    end

    assign shifted = (mem2proc_data >> {pend_head.addr[2:0], 3'b000}) & size_mask;

    assign mem_wr_en    = live_hit;
    assign mem_wr_idx   = pend_head.addr[3 +: IDX_W];
    assign mem_wr_tag   = pend_head.addr[8 +: CTAG_W];
    assign mem_wr_data  = mem2proc_data;
    assign mem_feedback = live_hit ? pend_head.gnt[LSQ_SIZE-1:0] : '0;
    assign mem_data     = live_hit ? shifted[31:0] : '0;

endmodule

// ==== verilog/dcache_ctrl.sv ====
//##########################################################################
// memory-side controller for a write-back, no-write-allocate dcache
//##########################################################################

`timescale 1ns/1ps

module dcache_ctrl
    import dcache_mem_pkg::*;
#(
    parameter int LSQ_SIZE    = 16,
    parameter int ISSUE_DEPTH = 32,
    parameter int PEND_DEPTH  = 16,
    parameter int RETRY_WAIT  = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  except,
    input  logic                  wb_en,
    input  logic [ADDR_W-1:0]     wb_addr,
    input  logic [63:0]           wb_data,
    input  logic                  wr_en,
    input  logic [ADDR_W-1:0]     wr_addr,
    input  logic [63:0]           wr_data,
    input  mem_size_t             wr_size,
    input  logic                  rd_en,
    input  logic [ADDR_W-1:0]     rd_addr,
    input  mem_size_t             rd_size,
    input  logic [LSQ_SIZE-1:0]   rd_gnt,
    input  logic [MEM_TAG_W-1:0]  mem2proc_response,
    input  logic [63:0]           mem2proc_data,
    input  logic [MEM_TAG_W-1:0]  mem2proc_tag,
    output bus_cmd_t              Dmem_command,
    output logic [ADDR_W-1:0]     Dmem_addr,
    output mem_size_t             Dmem_size,
    output logic [63:0]           Dmem_data,
    output logic [LSQ_SIZE-1:0]   mem_feedback,
    output logic [31:0]           mem_data,
    output logic                  mem_wr_en,
    output logic [IDX_W-1:0]      mem_wr_idx,
    output logic [CTAG_W-1:0]     mem_wr_tag,
    output logic [63:0]           mem_wr_data
);

    logic [2:0]     push_valid;
    mem_req_t [2:0] push_data;
    logic [2:0]     push_cancelable;

    mem_req_t issue_head;
    logic     issue_live;
    logic     issue_empty;
    logic     issue_pop;

    pend_t    pend_data;
    pend_t    pend_head;
    logic     pend_push;
    logic     pend_live;
    logic     pend_empty;
    logic     pend_full;
    logic     pend_pop;

    logic     timer_start;
    logic     timer_busy;

    miss_request_packer #(.LSQ_SIZE(LSQ_SIZE)) packer (
        .clock, .reset, .except,
        .wb_en, .wb_addr, .wb_data,
        .wr_en, .wr_addr, .wr_data, .wr_size,
        .rd_en, .rd_addr, .rd_size, .rd_gnt,
        .push_valid, .push_data, .push_cancelable
    );

    // commands not yet accepted by memory
    tag_fifo #(.payload_t(mem_req_t), .DEPTH(ISSUE_DEPTH), .PUSH_LANES(3)) issue_q (
        .clock, .reset, .kill(except),
        .push_valid, .push_data, .push_cancelable,
        .pop(issue_pop),
        .head_data(issue_head), .head_live(issue_live),
        .empty(issue_empty), .full(), .free_count()
    );

    issue_fsm fsm (
        .clock, .reset,
        .head_data(issue_head), .head_live(issue_live),
        .issue_empty, .pend_full, .mem2proc_response, .timer_busy,
        .issue_pop, .pend_push, .pend_data, .timer_start,
        .Dmem_command, .Dmem_addr, .Dmem_size, .Dmem_data
    );

    retry_timer #(.RETRY_WAIT(RETRY_WAIT)) backoff (
        .clock, .reset, .start(timer_start), .busy(timer_busy)
    );

    // accepted loads waiting for their tag, every one cancelable
    tag_fifo #(.payload_t(pend_t), .DEPTH(PEND_DEPTH), .PUSH_LANES(1)) pend_q (
        .clock, .reset, .kill(except),
        .push_valid(pend_push), .push_data(pend_data), .push_cancelable(1'b1),
        .pop(pend_pop),
        .head_data(pend_head), .head_live(pend_live),
        .empty(pend_empty), .full(pend_full), .free_count()
    );

    load_aligner #(.LSQ_SIZE(LSQ_SIZE)) aligner (
        .pend_head, .pend_live, .pend_empty, .mem2proc_tag, .mem2proc_data,
        .pend_pop, .mem_wr_en, .mem_wr_idx, .mem_wr_tag, .mem_wr_data,
        .mem_feedback, .mem_data
    );

endmodule

// ==== test/mem_responder.sv ====
//##########################################################################
// behavioral tagged memory with random refusal and in-order load returns
//##########################################################################

`timescale 1ns/1ps

module mem_responder
    import dcache_mem_pkg::*;
#(
    parameter int MAX_DELAY = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  bus_cmd_t              Dmem_command,
    input  logic [ADDR_W-1:0]     Dmem_addr,
    input  mem_size_t             Dmem_size,
    input  logic [63:0]           Dmem_data,
    output logic [MEM_TAG_W-1:0]  mem2proc_response,
    output logic [63:0]           mem2proc_data,
    output logic [MEM_TAG_W-1:0]  mem2proc_tag
);

    logic [7:0]           mem [65536];
    integer               seed;
    logic                 refuse;
    logic [MEM_TAG_W-1:0] next_tag;
    longint               cycle;
    logic [MEM_TAG_W-1:0] ret_tag [$];
    logic [63:0]          ret_data [$];
    longint               ret_due [$];

    initial begin
        seed          = 32'h12de;
        refuse        = 1'b0;
        next_tag      = 4'd1;
        cycle         = 0;
        mem2proc_tag  = '0;
        mem2proc_data = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {a[2:0], a[7:3]} ^ a[15:8] ^ 8'h5a;
        end
    end

    // accept or refuse in the same cycle as the command
    assign mem2proc_response = (!reset && Dmem_command != BUS_NONE && !refuse) ? next_tag : '0;

    always @(posedge clock) begin
        logic [31:0]       r;
        logic [63:0]       dw;
        logic [ADDR_W-1:0] base;
        r = $random(seed);
        if (reset) begin
            refuse        <= 1'b0;
            next_tag      <= 4'd1;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
            ret_tag.delete();
            ret_data.delete();
            ret_due.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
            if (ret_tag.size() > 0 && cycle >= ret_due[0]) begin
                mem2proc_tag  <= ret_tag.pop_front();
                mem2proc_data <= ret_data.pop_front();
                void'(ret_due.pop_front());
            end
            if (mem2proc_response != '0) begin
                if (Dmem_command == BUS_STORE) begin
                    for (int i = 0; i < (1 << Dmem_size); i++) begin
                        mem[16'(Dmem_addr + 16'(i))] = Dmem_data[8*i +: 8];
                    end
                end else begin
                    base = {Dmem_addr[ADDR_W-1:3], 3'b000};
                    for (int i = 0; i < 8; i++) begin
                        dw[8*i +: 8] = mem[16'(base + 16'(i))];
                    end
                    ret_tag.push_back(mem2proc_response);
                    ret_data.push_back(dw);
                    ret_due.push_back(cycle + 1 + longint'(r[7:0] % MAX_DELAY));
                end
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            // about one in four refused
            refuse <= (r[31:30] == 2'b00);
        end
    end

endmodule

// ==== test/dcache_ctrl_tb.sv ====
//##########################################################################
// dcache controller testbench with random requests, reference model, checks
//##########################################################################

`timescale 1ns/1ps

module dcache_ctrl_tb
    import dcache_mem_pkg::*;
;

    localparam int LSQ_SIZE     = 16;
    localparam int RETRY_WAIT   = 2;
    localparam int RESET_CYCLES = 16;
    localparam int REQ_CYCLES   = 600;
    localparam int TIMEOUT      = 4000;
    localparam int MAX_QUEUED   = 20;

    typedef struct {
        logic              is_store;
        logic [ADDR_W-1:0] addr;
        mem_size_t         size;
        logic [63:0]       data;
        logic [15:0]       gnt;
    } cmd_t;

    typedef struct {
        logic [ADDR_W-1:0] addr;
        mem_size_t         size;
        logic [15:0]       gnt;
        logic [63:0]       dw;
        logic              cancelled;
    } res_t;

    logic clock, reset, except;
    logic wb_en, wr_en, rd_en;
    logic [ADDR_W-1:0] wb_addr, wr_addr, rd_addr, Dmem_addr;
    logic [63:0] wb_data, wr_data, mem2proc_data, Dmem_data, mem_wr_data;
    mem_size_t wr_size, rd_size, Dmem_size;
    logic [LSQ_SIZE-1:0] rd_gnt, mem_feedback;
    logic [MEM_TAG_W-1:0] mem2proc_response, mem2proc_tag;
    bus_cmd_t Dmem_command;
    logic [31:0] mem_data;
    logic mem_wr_en;
    logic [IDX_W-1:0] mem_wr_idx;
    logic [CTAG_W-1:0] mem_wr_tag;

    integer seed;
    longint cycle;
    longint refuse_cycle;
    logic   retry_pending;
    logic [7:0] model_mem [65536];
    cmd_t exp_cmd [$];
    res_t exp_res [$];

    dcache_ctrl #(.LSQ_SIZE(LSQ_SIZE), .RETRY_WAIT(RETRY_WAIT)) DUT (
        .clock, .reset, .except,
        .wb_en, .wb_addr, .wb_data,
        .wr_en, .wr_addr, .wr_data, .wr_size,
        .rd_en, .rd_addr, .rd_size, .rd_gnt,
        .mem2proc_response, .mem2proc_data, .mem2proc_tag,
        .Dmem_command, .Dmem_addr, .Dmem_size, .Dmem_data,
        .mem_feedback, .mem_data, .mem_wr_en, .mem_wr_idx, .mem_wr_tag, .mem_wr_data
    );

    mem_responder memory (
        .clock, .reset, .Dmem_command, .Dmem_addr, .Dmem_size, .Dmem_data,
        .mem2proc_response, .mem2proc_data, .mem2proc_tag
    );

    always #10 clock = ~clock;

    initial begin
        clock   = 1'b0;
        reset   = 1'b1;
        except  = 1'b0;
        wb_en   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_size = BYTE;
        rd_en   = 1'b0;
        rd_addr = '0;
        rd_size = BYTE;
        rd_gnt  = '0;
        seed = 32'h12de;
        cycle = 0;
        retry_pending = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            model_mem[a] = {a[2:0], a[7:3]} ^ a[15:8] ^ 8'h5a;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                         name, got, exp));
    endtask

    // lsq value shifted to the byte offset and cut to the size
    function automatic logic [31:0] aligned_value(input logic [63:0] dw,
                                                  input logic [ADDR_W-1:0] addr,
                                                  input mem_size_t size);
        logic [63:0] v;
        v = dw >> (8 * addr[2:0]);
        case (size)
            BYTE:    v = v & 64'hff;
            HALF:    v = v & 64'hffff;
            WORD:    v = v & 64'hffff_ffff;
            default: v = v;
        endcase
        return v[31:0];
    endfunction

    function automatic logic [63:0] model_dword(input logic [ADDR_W-1:0] addr);
        logic [63:0] dw;
        for (int i = 0; i < 8; i++) begin
            dw[8*i +: 8] = model_mem[{addr[ADDR_W-1:3], 3'(i)}];
        end
        return dw;
    endfunction

    function automatic logic [ADDR_W-1:0] region_addr(input logic [8:0] r,
                                                      input mem_size_t size);
        logic [ADDR_W-1:0] a;
        a = {7'h1d, r};
        return a & ~((16'd1 << size) - 16'd1);
    endfunction

    task automatic check_bus();
        cmd_t c;
        res_t e;
        if (Dmem_command != BUS_NONE) begin
            assert (exp_cmd.size() != 0)
            else stop_with_failure("bus command seen with no request outstanding");
            c = exp_cmd[0];
            check_value("Dmem_command", Dmem_command, c.is_store ? BUS_STORE : BUS_LOAD);
            check_value("Dmem_addr", Dmem_addr, c.addr);
            check_value("Dmem_size", Dmem_size, c.is_store ? c.size : DOUBLE);
            if (c.is_store)
                check_value("Dmem_data", Dmem_data, c.data);
            if (retry_pending) begin
                assert (cycle - refuse_cycle > RETRY_WAIT)
                else stop_with_failure("command retried before the backoff ended");
                retry_pending = 1'b0;
            end
            if (mem2proc_response != '0) begin
                void'(exp_cmd.pop_front());
                if (c.is_store) begin
                    for (int i = 0; i < (1 << c.size); i++) begin
                        model_mem[16'(c.addr + 16'(i))] = c.data[8*i +: 8];
                    end
                end else begin
                    e = '{addr: c.addr, size: c.size, gnt: c.gnt,
                          dw: model_dword(c.addr), cancelled: 1'b0};
                    exp_res.push_back(e);
                end
            end else begin
                retry_pending = 1'b1;
                refuse_cycle  = cycle;
            end
        end
    endtask

    task automatic check_return();
        res_t e;
        if (mem2proc_tag != '0) begin
            assert (exp_res.size() != 0)
            else stop_with_failure("load data returned with no load outstanding");
            e = exp_res.pop_front();
            if (!e.cancelled) begin
                check_value("mem_wr_en", mem_wr_en, 1'b1);
                check_value("mem_wr_idx", mem_wr_idx, e.addr[7:3]);
                check_value("mem_wr_tag", mem_wr_tag, e.addr[15:8]);
                check_value("mem_wr_data", mem_wr_data, e.dw);
                check_value("mem_feedback", mem_feedback, e.gnt);
                check_value("mem_data", mem_data, aligned_value(e.dw, e.addr, e.size));
                return;
            end
        end
        check_value("mem_wr_en", mem_wr_en, 1'b0);
        check_value("mem_feedback", mem_feedback, '0);
    endtask

    // loads not yet accepted vanish, accepted ones return silently
    task automatic apply_except();
        cmd_t kept [$];
        foreach (exp_cmd[i]) begin
            if (exp_cmd[i].is_store)
                kept.push_back(exp_cmd[i]);
        end
        exp_cmd = kept;
        foreach (exp_res[i]) begin
            exp_res[i].cancelled = 1'b1;
        end
    endtask

    task automatic drive_requests();
        logic [31:0] r, a, b;
        cmd_t c;
        mem_size_t sz;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        wb_en <= 1'b0;
        wr_en <= 1'b0;
        rd_en <= 1'b0;
        except <= (r[23:16] < 8'd3);
        if (exp_cmd.size() < MAX_QUEUED) begin
            if (r[3:0] < 4'd2) begin
                c = '{is_store: 1'b1, addr: region_addr(a[8:0], DOUBLE), size: DOUBLE,
                      data: {$random(seed), $random(seed)}, gnt: '0};
                wb_en   <= 1'b1;
                wb_addr <= c.addr;
                wb_data <= c.data;
                exp_cmd.push_back(c);
            end
            if (r[7:4] < 4'd3) begin
                sz = mem_size_t'(b[1:0]);
                c = '{is_store: 1'b1, addr: region_addr(a[17:9], sz), size: sz,
                      data: {$random(seed), $random(seed)}, gnt: '0};
                wr_en   <= 1'b1;
                wr_addr <= c.addr;
                wr_data <= c.data;
                wr_size <= sz;
                exp_cmd.push_back(c);
            end
            if (r[11:8] < 4'd4) begin
                sz = mem_size_t'(b[3:2]);
                c = '{is_store: 1'b0, addr: region_addr(a[26:18], sz), size: sz,
                      data: '0, gnt: 16'd1 << b[7:4]};
                rd_en   <= 1'b1;
                rd_addr <= c.addr;
                rd_size <= sz;
                rd_gnt  <= c.gnt;
                exp_cmd.push_back(c);
            end
        end
    endtask

    always @(posedge clock) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT)
            stop_with_failure("timeout: requests still outstanding at the cycle limit");
        if (reset) begin
            if (cycle == RESET_CYCLES) begin
                check_value("Dmem_command", Dmem_command, BUS_NONE);
                check_value("mem_wr_en", mem_wr_en, 1'b0);
                check_value("mem_feedback", mem_feedback, '0);
                reset <= 1'b0;
            end
        end else begin
            check_bus();
            check_return();
            if (except)
                apply_except();
            if (cycle <= RESET_CYCLES + REQ_CYCLES) begin
                drive_requests();
            end else begin
                wb_en  <= 1'b0;
                wr_en  <= 1'b0;
                rd_en  <= 1'b0;
                except <= 1'b0;
                if (cycle > RESET_CYCLES + REQ_CYCLES + 2 && exp_cmd.size() == 0
                        && exp_res.size() == 0) begin
                    $display(">>> PASS");
                    $finish;
                end
            end
        end
    end

endmodule

// ==== compile.f ====
verilog/dcache_mem_pkg.sv
verilog/miss_request_packer.sv
verilog/tag_fifo.sv
verilog/issue_fsm.sv
verilog/retry_timer.sv
verilog/load_aligner.sv
verilog/dcache_ctrl.sv
test/mem_responder.sv
test/dcache_ctrl_tb.sv

// ==== run.sh ====
#!/bin/bash
# builds the dcache controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module dcache_ctrl_tb \
    -f compile.f \
    -o dcache_ctrl_sim \
    && ./obj_dir/dcache_ctrl_sim \
    || exit 1
